//--- verilog.f
+incdir+hdl
hdl/axil_pkg.sv
hdl/mem_map_pkg.sv
hdl/axil_if.sv
hdl/axil_arbiter.sv
hdl/axil_addr_decoder.sv
hdl/axil_resp_merge.sv
hdl/axil_ram_bank.sv
hdl/axil_mem_subsys.sv
sim/tb_axil_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axil_mem_subsys
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_axil_mem_subsys.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_axil_mem_subsys import axil_pkg::*; ();

    localparam int          TIMEOUT   = 50;
    localparam int unsigned MAP_BYTES = `NUM_BANKS * `BANK_WORDS * 4;

    logic       clk;
    logic       rst_n;
    addr_t      fetch_araddr;
    logic       fetch_arvalid;
    logic       fetch_arready;
    data_t      fetch_rdata;
    axil_resp_e fetch_rresp;
    logic       fetch_rvalid;
    logic       fetch_rready;
    addr_t      lsu_araddr;
    logic       lsu_arvalid;
    logic       lsu_arready;
    data_t      lsu_rdata;
    axil_resp_e lsu_rresp;
    logic       lsu_rvalid;
    logic       lsu_rready;
    addr_t      lsu_awaddr;
    logic       lsu_awvalid;
    logic       lsu_awready;
    data_t      lsu_wdata;
    strb_t      lsu_wstrb;
    logic       lsu_wvalid;
    logic       lsu_wready;
    axil_resp_e lsu_bresp;
    logic       lsu_bvalid;
    logic       lsu_bready;

    // reference memory, keyed by word number
    data_t       ref_mem [int unsigned];
    addr_t       written [$];
    int unsigned lsu_rsp_cnt;
    int unsigned prio_mark;
    logic        prio_armed;
    logic        rst_q;
    logic        fetch_active;
    logic        lsu_active;

    axil_mem_subsys i_axil_mem_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        rst_q <= rst_n;
    end

    assign fetch_active = fetch_arready || fetch_rvalid;
    assign lsu_active   = lsu_arready || lsu_rvalid || lsu_awready || lsu_wready || lsu_bvalid;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // quiet during reset and the first cycle after it
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n || !rst_q |-> !fetch_active && !lsu_active)
        else report_failure("a ready or valid output was active around reset");

    // only the granted master ever sees handshake signals
    a_one_master: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_active && lsu_active))
        else report_failure("fetch and lsu were both served in the same cycle");

    a_fetch_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rvalid && !fetch_rready |=>
            fetch_rvalid && $stable(fetch_rdata) && $stable(fetch_rresp))
        else report_failure("fetch read response changed before its handshake");

    a_lsu_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
        else report_failure("lsu read response changed before its handshake");

    a_lsu_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_bvalid && !lsu_bready |=> lsu_bvalid && $stable(lsu_bresp))
        else report_failure("lsu write response changed before its handshake");

    // lsu wins a tie, fetch waits for its whole transaction
    a_priority: assert property (@(posedge clk) disable iff (!rst_n)
        prio_armed && fetch_arready |-> lsu_rsp_cnt != prio_mark)
        else report_failure("fetch was accepted before the lsu response finished");

    task automatic next_sample(inout int n, input string what);
        @(negedge clk);
        n++;
        if (n > TIMEOUT) begin
            report_failure($sformatf("timeout waiting for %s", what));
        end
    endtask

    function automatic data_t merge_bytes(data_t old, data_t data, strb_t strb);
        data_t r;
        r = old;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                r[8*i +: 8] = data[8*i +: 8];
            end
        end
        return r;
    endfunction

    task automatic fetch_read(input addr_t addr, input int stall, input data_t exp_data,
                              input axil_resp_e exp_resp);
        int n;
        fetch_araddr  = addr;
        fetch_arvalid = 1'b1;
        n = 0;
        do begin
            next_sample(n, "fetch_arready");
        end while (!fetch_arready);
        @(posedge clk);
        #1;
        fetch_arvalid = 1'b0;
        n = 0;
        do begin
            next_sample(n, "fetch_rvalid");
        end while (!fetch_rvalid);
        // hold rready low a while
        repeat (stall + 1) @(posedge clk);
        #1;
        fetch_rready = 1'b1;
        @(negedge clk);
        expect_equal("fetch_rdata", fetch_rdata, exp_data);
        expect_equal("fetch_rresp", 32'(fetch_rresp), 32'(exp_resp));
        @(posedge clk);
        #1;
        fetch_rready = 1'b0;
    endtask

    task automatic lsu_read(input addr_t addr, input int stall, input data_t exp_data,
                            input axil_resp_e exp_resp);
        int n;
        lsu_araddr  = addr;
        lsu_arvalid = 1'b1;
        n = 0;
        do begin
            next_sample(n, "lsu_arready");
        end while (!lsu_arready);
        @(posedge clk);
        #1;
        lsu_arvalid = 1'b0;
        n = 0;
        do begin
            next_sample(n, "lsu_rvalid");
        end while (!lsu_rvalid);
        repeat (stall + 1) @(posedge clk);
        #1;
        lsu_rready = 1'b1;
        @(negedge clk);
        expect_equal("lsu_rdata", lsu_rdata, exp_data);
        expect_equal("lsu_rresp", 32'(lsu_rresp), 32'(exp_resp));
        @(posedge clk);
        #1;
        lsu_rready = 1'b0;
        lsu_rsp_cnt++;
    endtask

    task automatic lsu_write(input addr_t addr, input data_t data, input strb_t strb,
                             input int stall, input axil_resp_e exp_resp);
        int   n;
        logic aw_hs;
        logic w_hs;
        lsu_awaddr  = addr;
        lsu_awvalid = 1'b1;
        lsu_wdata   = data;
        lsu_wstrb   = strb;
        lsu_wvalid  = 1'b1;
        n = 0;
        // aw and w may be taken in different cycles
        while (lsu_awvalid || lsu_wvalid) begin
            next_sample(n, "lsu_awready and lsu_wready");
            aw_hs = lsu_awvalid && lsu_awready;
            w_hs  = lsu_wvalid && lsu_wready;
            @(posedge clk);
            #1;
            if (aw_hs) begin
                lsu_awvalid = 1'b0;
            end
            if (w_hs) begin
                lsu_wvalid = 1'b0;
            end
        end
        n = 0;
        do begin
            next_sample(n, "lsu_bvalid");
        end while (!lsu_bvalid);
        repeat (stall + 1) @(posedge clk);
        #1;
        lsu_bready = 1'b1;
        @(negedge clk);
        expect_equal("lsu_bresp", 32'(lsu_bresp), 32'(exp_resp));
        @(posedge clk);
        #1;
        lsu_bready = 1'b0;
        lsu_rsp_cnt++;
    endtask

    // expected response follows the address map
    task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
        axil_resp_e  exp_resp;
        int unsigned w;
        exp_resp = DECERR;
        if (addr < MAP_BYTES) begin
            w = addr >> 2;
            ref_mem[w] = ref_mem.exists(w) ? merge_bytes(ref_mem[w], data, strb) : data;
            exp_resp = OKAY;
        end
        lsu_write(addr, data, strb, $urandom % 8, exp_resp);
    endtask

    task automatic read_word(input logic use_fetch, input addr_t addr);
        data_t       exp_data;
        axil_resp_e  exp_resp;
        int unsigned w;
        int          stall;
        exp_data = '0;
        exp_resp = DECERR;
        stall    = $urandom % 8;
        if (addr < MAP_BYTES) begin
            w = addr >> 2;
            exp_data = ref_mem[w];
            exp_resp = OKAY;
        end
        if (use_fetch) begin
            fetch_read(addr, stall, exp_data, exp_resp);
        end else begin
            lsu_read(addr, stall, exp_data, exp_resp);
        end
    endtask

    task automatic wait_fetch_accept();
        int n;
        n = 0;
        do begin
            next_sample(n, "fetch_arready");
        end while (!fetch_arready);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int unsigned word;
        addr_t       a;
        void'($urandom(32'h5ff46af3));
        rst_n         = 1'b0;
        fetch_araddr  = '0;
        fetch_arvalid = 1'b0;
        fetch_rready  = 1'b0;
        lsu_araddr    = '0;
        lsu_arvalid   = 1'b0;
        lsu_rready    = 1'b0;
        lsu_awaddr    = '0;
        lsu_awvalid   = 1'b0;
        lsu_wdata     = '0;
        lsu_wstrb     = '0;
        lsu_wvalid    = 1'b0;
        lsu_bready    = 1'b0;
        lsu_rsp_cnt   = 0;
        prio_mark     = 0;
        prio_armed    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        // full word first, then a random strobe on top
        for (int b = 0; b < `NUM_BANKS; b++) begin
            for (int k = 0; k < 3; k++) begin
                word = b * `BANK_WORDS + ($urandom % `BANK_WORDS);
                a    = word * 4;
                written.push_back(a);
                write_word(a, data_t'($urandom), '1);
                write_word(a, data_t'($urandom), strb_t'($urandom));
            end
        end
        for (int i = 0; i < written.size(); i++) begin
            read_word(i % 2 == 1, written[i]);
        end

        // same-cycle requests from both masters
        prio_mark  = lsu_rsp_cnt;
        prio_armed = 1'b1;
        fork
            write_word(written[0], data_t'($urandom), strb_t'($urandom));
            read_word(1'b1, written[written.size() - 1]);
        join
        prio_armed = 1'b0;
        read_word(1'b0, written[0]);

        // lsu arrives while a fetch read holds the grant
        for (int k = 0; k < 2; k++) begin
            fork
                read_word(1'b1, written[3]);
                begin
                    wait_fetch_accept();
                    if (k == 0) begin
                        read_word(1'b0, written[9]);
                    end else begin
                        write_word(written[9], data_t'($urandom), strb_t'($urandom));
                    end
                end
            join
        end
        read_word(1'b1, written[9]);

        // unmapped space, then the aliased low word
        a = written[4];
        read_word(1'b0, a + MAP_BYTES);
        read_word(1'b1, a + MAP_BYTES);
        write_word(a + MAP_BYTES, data_t'($urandom), '1);
        write_word(a | 32'h8000_0000, data_t'($urandom), '1);
        read_word(1'b0, a | 32'h8000_0000);
        read_word(1'b0, a);
        read_word(1'b1, a);

        // random traffic, every response stalled a random time
        for (int i = 0; i < 16; i++) begin
            a = written[$urandom % written.size()];
            case ($urandom % 3)
                0: write_word(a, data_t'($urandom), strb_t'($urandom));
                1: read_word(1'b0, a);
                default: read_word(1'b1, a);
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- hdl/axil_mem_subsys.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module axil_mem_subsys import axil_pkg::*, mem_map_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  addr_t      fetch_araddr,
    input  logic       fetch_arvalid,
    output logic       fetch_arready,
    output data_t      fetch_rdata,
    output axil_resp_e fetch_rresp,
    output logic       fetch_rvalid,
    input  logic       fetch_rready,

    input  addr_t      lsu_araddr,
    input  logic       lsu_arvalid,
    output logic       lsu_arready,
    output data_t      lsu_rdata,
    output axil_resp_e lsu_rresp,
    output logic       lsu_rvalid,
    input  logic       lsu_rready,
    input  addr_t      lsu_awaddr,
    input  logic       lsu_awvalid,
    output logic       lsu_awready,
    input  data_t      lsu_wdata,
    input  strb_t      lsu_wstrb,
    input  logic       lsu_wvalid,
    output logic       lsu_wready,
    output axil_resp_e lsu_bresp,
    output logic       lsu_bvalid,
    input  logic       lsu_bready
);

    axil_if  bus_if ();
    axil_if  bank_if [`NUM_BANKS] ();
    target_t rd_target;
    target_t wr_target;

    axil_arbiter i_axil_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_araddr  (fetch_araddr),
        .fetch_arvalid (fetch_arvalid),
        .fetch_arready (fetch_arready),
        .fetch_rdata   (fetch_rdata),
        .fetch_rresp   (fetch_rresp),
        .fetch_rvalid  (fetch_rvalid),
        .fetch_rready  (fetch_rready),
        .lsu_araddr    (lsu_araddr),
        .lsu_arvalid   (lsu_arvalid),
        .lsu_arready   (lsu_arready),
        .lsu_rdata     (lsu_rdata),
        .lsu_rresp     (lsu_rresp),
        .lsu_rvalid    (lsu_rvalid),
        .lsu_rready    (lsu_rready),
        .lsu_awaddr    (lsu_awaddr),
        .lsu_awvalid   (lsu_awvalid),
        .lsu_awready   (lsu_awready),
        .lsu_wdata     (lsu_wdata),
        .lsu_wstrb     (lsu_wstrb),
        .lsu_wvalid    (lsu_wvalid),
        .lsu_wready    (lsu_wready),
        .lsu_bresp     (lsu_bresp),
        .lsu_bvalid    (lsu_bvalid),
        .lsu_bready    (lsu_bready),
        .bus           (bus_if.master)
    );

    axil_addr_decoder i_axil_addr_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus_if.req_slave),
        .banks     (bank_if),
        .rd_target (rd_target),
        .wr_target (wr_target)
    );

    axil_resp_merge i_axil_resp_merge (
        .rd_target (rd_target),
        .wr_target (wr_target),
        .banks     (bank_if),
        .bus       (bus_if.rsp_slave)
    );

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_ram
        axil_ram_bank i_axil_ram_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .s     (bank_if[g].slave)
        );
    end

endmodule

//--- hdl/axil_ram_bank.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module axil_ram_bank import axil_pkg::*, mem_map_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    axil_if.slave  s
);

    data_t mem [`BANK_WORDS];

    logic  aw_done;
    logic  w_done;
    addr_t awaddr_q;
    data_t wdata_q;
    strb_t wstrb_q;
    addr_t wr_addr;
    data_t wr_data;
    strb_t wr_strb;
    logic  ar_fire;
    logic  aw_fire;
    logic  w_fire;
    logic  wr_go;

    assign ar_fire = s.arvalid && s.arready;
    assign aw_fire = s.awvalid && s.awready;
    assign w_fire  = s.wvalid && s.wready;

    assign s.arready = !s.rvalid;
    assign s.awready = !aw_done && !s.bvalid;
    assign s.wready  = !w_done && !s.bvalid;
    assign s.rresp   = OKAY;
    assign s.bresp   = OKAY;

    // second of aw and w completes the write, in either order
    assign wr_go   = (aw_fire || aw_done) && (w_fire || w_done);
    assign wr_addr = aw_done ? awaddr_q : s.awaddr;
    assign wr_data = w_done ? wdata_q : s.wdata;
    assign wr_strb = w_done ? wstrb_q : s.wstrb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s.rvalid <= 1'b0;
            s.bvalid <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            if (ar_fire) begin
                s.rvalid <= 1'b1;
            end else if (s.rready) begin
                s.rvalid <= 1'b0;
            end
            if (wr_go) begin
                s.bvalid <= 1'b1;
            end else if (s.bready) begin
                s.bvalid <= 1'b0;
            end
            aw_done <= wr_go ? 1'b0 : (aw_done || aw_fire);
            w_done  <= wr_go ? 1'b0 : (w_done || w_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            s.rdata <= mem[s.araddr[BYTE_OFF_W +: WORD_OFF_W]];
        end
        if (aw_fire) begin
            awaddr_q <= s.awaddr;
        end
        if (w_fire) begin
            wdata_q <= s.wdata;
            wstrb_q <= s.wstrb;
        end
        // byte lanes with strobe set
        if (wr_go) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr[BYTE_OFF_W +: WORD_OFF_W]][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s.rvalid && !s.rready |=> s.rvalid && $stable(s.rdata));

endmodule

//--- hdl/axil_resp_merge.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module axil_resp_merge import axil_pkg::*, mem_map_pkg::*; (
    input  target_t    rd_target,
    input  target_t    wr_target,
    axil_if.rsp_master banks [`NUM_BANKS],
    axil_if.rsp_slave  bus
);

    logic [`NUM_BANKS-1:0] bank_rvalid;
    logic [`NUM_BANKS-1:0] bank_bvalid;
    data_t                 bank_rdata [`NUM_BANKS];
    axil_resp_e            bank_rresp [`NUM_BANKS];
    axil_resp_e            bank_bresp [`NUM_BANKS];

    // gather bank responses, ready goes to the targeted bank only
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        assign bank_rvalid[i] = banks[i].rvalid;
        assign bank_rdata[i]  = banks[i].rdata;
        assign bank_rresp[i]  = banks[i].rresp;
        assign bank_bvalid[i] = banks[i].bvalid;
        assign bank_bresp[i]  = banks[i].bresp;

        assign banks[i].rready = bus.rready && !rd_target.err &&
                                 rd_target.bank == bank_idx_t'(i);
        assign banks[i].bready = bus.bready && !wr_target.err &&
                                 wr_target.bank == bank_idx_t'(i);
    end

    // the registered err bit of a target is the pending DECERR response
    assign bus.rvalid = rd_target.err ? 1'b1 : bank_rvalid[rd_target.bank];
    assign bus.rdata  = rd_target.err ? '0 : bank_rdata[rd_target.bank];
    assign bus.rresp  = rd_target.err ? DECERR : bank_rresp[rd_target.bank];

    assign bus.bvalid = wr_target.err ? 1'b1 : bank_bvalid[wr_target.bank];
    assign bus.bresp  = wr_target.err ? DECERR : bank_bresp[wr_target.bank];

endmodule

//--- hdl/axil_addr_decoder.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module axil_addr_decoder import axil_pkg::*, mem_map_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    axil_if.req_slave     bus,
    axil_if.req_master    banks [`NUM_BANKS],
    output target_t       rd_target,
    output target_t       wr_target
);

    function automatic target_t decode(addr_t addr);
        target_t t;
        t.err  = ({1'b0, addr} >= MAP_BYTES);
        t.bank = addr[BANK_LSB +: BANK_IDX_W];
        return t;
    endfunction

    target_t ar_dec;
    target_t aw_dec;
    target_t w_tgt;
    logic    w_route;
    logic    rd_busy;
    logic    wr_busy;

    logic [`NUM_BANKS-1:0] bank_arready;
    logic [`NUM_BANKS-1:0] bank_awready;
    logic [`NUM_BANKS-1:0] bank_wready;

    assign ar_dec = decode(bus.araddr);
    assign aw_dec = decode(bus.awaddr);

    // w follows an accepted aw, else the aw still on the bus
    assign w_tgt   = wr_busy ? wr_target : aw_dec;
    assign w_route = wr_busy || bus.awvalid;

    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        assign banks[i].araddr  = bus.araddr;
        assign banks[i].arvalid = bus.arvalid && !rd_busy && !ar_dec.err &&
                                  ar_dec.bank == bank_idx_t'(i);
        assign banks[i].awaddr  = bus.awaddr;
        assign banks[i].awvalid = bus.awvalid && !wr_busy && !aw_dec.err &&
                                  aw_dec.bank == bank_idx_t'(i);
        assign banks[i].wdata   = bus.wdata;
        assign banks[i].wstrb   = bus.wstrb;
        assign banks[i].wvalid  = bus.wvalid && w_route && !w_tgt.err &&
                                  w_tgt.bank == bank_idx_t'(i);
        assign bank_arready[i]  = banks[i].arready;
        assign bank_awready[i]  = banks[i].awready;
        assign bank_wready[i]   = banks[i].wready;
    end

    // unmapped writes take aw and w together in one cycle
    assign bus.arready = !rd_busy && (ar_dec.err || bank_arready[ar_dec.bank]);
    assign bus.awready = !wr_busy &&
                         (aw_dec.err ? bus.wvalid : bank_awready[aw_dec.bank]);
    assign bus.wready  = w_route &&
                         (w_tgt.err ? (!wr_busy && bus.awvalid) : bank_wready[w_tgt.bank]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_busy   <= 1'b0;
            rd_target <= '0;
        end else if (bus.arvalid && bus.arready) begin
            rd_busy   <= 1'b1;
            rd_target <= ar_dec;
        end else if (bus.rvalid && bus.rready) begin
            rd_busy   <= 1'b0;
            rd_target <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_busy   <= 1'b0;
            wr_target <= '0;
        end else if (bus.awvalid && bus.awready) begin
            wr_busy   <= 1'b1;
            wr_target <= aw_dec;
        end else if (bus.bvalid && bus.bready) begin
            wr_busy   <= 1'b0;
            wr_target <= '0;
        end
    end

    // a merged response only shows while its target is held
    a_rd_target_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.rvalid |-> rd_busy);

    a_wr_target_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.bvalid |-> wr_busy);

endmodule

//--- hdl/axil_arbiter.sv
`timescale 1ns/1ps

module axil_arbiter import axil_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // fetch, read only
    input  addr_t      fetch_araddr,
    input  logic       fetch_arvalid,
    output logic       fetch_arready,
    output data_t      fetch_rdata,
    output axil_resp_e fetch_rresp,
    output logic       fetch_rvalid,
    input  logic       fetch_rready,

    // load/store unit
    input  addr_t      lsu_araddr,
    input  logic       lsu_arvalid,
    output logic       lsu_arready,
    output data_t      lsu_rdata,
    output axil_resp_e lsu_rresp,
    output logic       lsu_rvalid,
    input  logic       lsu_rready,
    input  addr_t      lsu_awaddr,
    input  logic       lsu_awvalid,
    output logic       lsu_awready,
    input  data_t      lsu_wdata,
    input  strb_t      lsu_wstrb,
    input  logic       lsu_wvalid,
    output logic       lsu_wready,
    output axil_resp_e lsu_bresp,
    output logic       lsu_bvalid,
    input  logic       lsu_bready,

    axil_if.master     bus
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_FETCH_RD,
        GNT_LSU_RD,
        GNT_LSU_WR
    } grant_e;

    grant_e grant;
    grant_e grant_next;

    // lsu wins ties, then the grant is held to the response handshake
    always_comb begin
        grant_next = grant;
        case (grant)
            GNT_IDLE: begin
                if (lsu_arvalid) begin
                    grant_next = GNT_LSU_RD;
                end else if (lsu_awvalid || lsu_wvalid) begin
                    grant_next = GNT_LSU_WR;
                end else if (fetch_arvalid) begin
                    grant_next = GNT_FETCH_RD;
                end
            end
            GNT_FETCH_RD, GNT_LSU_RD: begin
                if (bus.rvalid && bus.rready) begin
                    grant_next = GNT_IDLE;
                end
            end
            GNT_LSU_WR: begin
                if (bus.bvalid && bus.bready) begin
                    grant_next = GNT_IDLE;
                end
            end
            default: grant_next = GNT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= GNT_IDLE;
        end else begin
            grant <= grant_next;
        end
    end

    // channel mux, the losing master sees everything low
    always_comb begin
        bus.araddr    = '0;
        bus.arvalid   = 1'b0;
        bus.rready    = 1'b0;
        bus.awaddr    = '0;
        bus.awvalid   = 1'b0;
        bus.wdata     = '0;
        bus.wstrb     = '0;
        bus.wvalid    = 1'b0;
        bus.bready    = 1'b0;
        fetch_arready = 1'b0;
        fetch_rdata   = '0;
        fetch_rresp   = OKAY;
        fetch_rvalid  = 1'b0;
        lsu_arready   = 1'b0;
        lsu_rdata     = '0;
        lsu_rresp     = OKAY;
        lsu_rvalid    = 1'b0;
        lsu_awready   = 1'b0;
        lsu_wready    = 1'b0;
        lsu_bresp     = OKAY;
        lsu_bvalid    = 1'b0;
        case (grant)
            GNT_FETCH_RD: begin
                bus.araddr    = fetch_araddr;
                bus.arvalid   = fetch_arvalid;
                bus.rready    = fetch_rready;
                fetch_arready = bus.arready;
                fetch_rdata   = bus.rdata;
                fetch_rresp   = bus.rresp;
                fetch_rvalid  = bus.rvalid;
            end
            GNT_LSU_RD: begin
                bus.araddr  = lsu_araddr;
                bus.arvalid = lsu_arvalid;
                bus.rready  = lsu_rready;
                lsu_arready = bus.arready;
                lsu_rdata   = bus.rdata;
                lsu_rresp   = bus.rresp;
                lsu_rvalid  = bus.rvalid;
            end
            GNT_LSU_WR: begin
                bus.awaddr  = lsu_awaddr;
                bus.awvalid = lsu_awvalid;
                bus.wdata   = lsu_wdata;
                bus.wstrb   = lsu_wstrb;
                bus.wvalid  = lsu_wvalid;
                bus.bready  = lsu_bready;
                lsu_awready = bus.awready;
                lsu_wready  = bus.wready;
                lsu_bresp   = bus.bresp;
                lsu_bvalid  = bus.bvalid;
            end
            default: begin
            end
        endcase
    end

    // a read response only ever comes back under a read grant
    a_grant_locked: assert property (@(posedge clk) disable iff (!rst_n)
        bus.rvalid |-> grant == GNT_FETCH_RD || grant == GNT_LSU_RD);

    // write responses only ever come back under the lsu write grant
    a_no_fetch_write: assert property (@(posedge clk) disable iff (!rst_n)
        bus.bvalid |-> grant == GNT_LSU_WR);

endmodule

//--- hdl/axil_if.sv
`timescale 1ns/1ps

interface axil_if import axil_pkg::*; ();

    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    axil_resp_e rresp;
    logic       rvalid;
    logic       rready;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_e bresp;
    logic       bvalid;
    logic       bready;

    modport master (output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid,
                    bready,
                    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid);

    modport slave  (input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid,
                    bready,
                    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid);

    // request side split, response handshakes are visible for tracking
    modport req_master (output araddr, arvalid, awaddr, awvalid, wdata, wstrb, wvalid,
                        input  arready, awready, wready);
    modport req_slave  (input  araddr, arvalid, awaddr, awvalid, wdata, wstrb, wvalid,
                        input  rvalid, rready, bvalid, bready,
                        output arready, awready, wready);

    // response side split
    modport rsp_master (input  rdata, rresp, rvalid, bresp, bvalid,
                        output rready, bready);
    modport rsp_slave  (output rdata, rresp, rvalid, bresp, bvalid,
                        input  rready, bready);

endinterface

//--- hdl/mem_map_pkg.sv
`include "soc_settings.svh"

package mem_map_pkg;

    localparam int unsigned BANK_IDX_W = (`NUM_BANKS > 1) ? $clog2(`NUM_BANKS) : 1;
    localparam int unsigned BYTE_OFF_W = $clog2(`AXIL_DATA_W / 8);
    localparam int unsigned WORD_OFF_W = $clog2(`BANK_WORDS);

    // lowest address bit of the bank select field
    localparam int unsigned BANK_LSB = WORD_OFF_W + BYTE_OFF_W;

    // first unmapped byte address, one bit wider than the bus address
    localparam logic [`AXIL_ADDR_W:0] MAP_BYTES =
        (`AXIL_ADDR_W + 1)'(`NUM_BANKS * `BANK_WORDS * (`AXIL_DATA_W / 8));

    typedef logic [BANK_IDX_W-1:0] bank_idx_t;

    // err set means no bank answers, bank is then don't care
    typedef struct packed {
        logic      err;
        bank_idx_t bank;
    } target_t;

endpackage

//--- hdl/axil_pkg.sv
`include "soc_settings.svh"

package axil_pkg;

    // one strobe bit per data byte
    localparam int unsigned STRB_W = `AXIL_DATA_W / 8;

    typedef logic [`AXIL_ADDR_W-1:0] addr_t;
    typedef logic [`AXIL_DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0]       strb_t;

    // SLVERR and EXOKAY never occur in this subsystem
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axil_resp_e;

endpackage

//--- hdl/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths shared by every master and slave
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// on-chip ram layout
// banks sit back to back from address zero
`define NUM_BANKS   4

// words per bank, a power of two
`define BANK_WORDS  256

`endif
